// File: common/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [31:0] imm_t;

    typedef enum logic [3:0] {
        op_nop,
        op_lui,
        op_addi,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_lw,
        op_sw,
        op_beq,
        op_bne,
        op_jal
    } op_t;

    // reset vector
    localparam word_t start_addr = 32'h2000_0000;

    // rv32i major opcodes
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_opimm  = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

endpackage

`default_nettype wire

// File: common/stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// decode -> execute
interface dec_if import core_pkg::*; ();
    logic      valid;
    word_t     pc;
    op_t       op;
    reg_addr_t rd;
    word_t     rs1_data;
    word_t     rs2_data;
    imm_t      imm;

    modport src (output valid, pc, op, rd, rs1_data, rs2_data, imm);
    modport dst (input  valid, pc, op, rd, rs1_data, rs2_data, imm);
endinterface

// execute -> memory stage
interface exe_if import core_pkg::*; ();
    logic      valid;
    op_t       op;
    reg_addr_t rd;
    word_t     result;
    word_t     addr;
    word_t     wdata;

    modport src (output valid, op, rd, result, addr, wdata);
    modport dst (input  valid, op, rd, result, addr, wdata);
endinterface

`default_nettype wire

// File: fetch/fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch import core_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  mem_wait,
    input  logic  busy,
    input  logic  stall,
    input  logic  flush,
    input  word_t jmp_pc,

    output logic  inst_rden,
    output word_t inst_riaddr,
    input  logic  inst_rvalid,
    input  word_t inst_roaddr,
    input  inst_t inst_rdata,

    output logic  fetch_valid,
    output word_t fetch_pc,
    output inst_t fetch_inst
);

    word_t pc;
    logic  advance;
    logic  hit;
    logic  take;

    assign inst_riaddr = pc;
    assign advance     = !mem_wait && !busy;

    // only a response for the current pc counts
    assign hit  = inst_rden && inst_rvalid && (inst_roaddr == pc);
    assign take = advance && !flush && !stall && hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= start_addr;
            inst_rden   <= 1'b0;
            fetch_valid <= 1'b0;
        end else if (advance) begin
            inst_rden <= 1'b1;
            if (flush) begin
                pc          <= jmp_pc;
                fetch_valid <= 1'b0;
            end else if (!stall) begin
                fetch_valid <= hit;
                if (hit) begin
                    pc <= pc + 32'd4;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            fetch_pc   <= pc;
            fetch_inst <= inst_rdata;
        end
    end

endmodule

`default_nettype wire

// File: decode/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      mem_wait,
    input  logic      busy,
    input  logic      flush,
    input  logic      fetch_valid,
    input  word_t     fetch_pc,
    input  inst_t     fetch_inst,

    output logic      stall,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  logic      rs1_pending,
    input  logic      rs2_pending,
    output reg_addr_t issue_rd,
    output logic      issue_en,

    dec_if.src        d
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    op_t        op;
    imm_t       imm;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       writes_rd;
    logic       advance;
    logic       issue;

    assign opcode = fetch_inst[6:0];
    assign funct3 = fetch_inst[14:12];
    assign funct7 = fetch_inst[31:25];

    always_comb begin
        op  = op_nop;
        imm = '0;
        case (opcode)
            opc_lui: begin
                op  = op_lui;
                imm = {fetch_inst[31:12], 12'b0};
            end
            opc_opimm: begin
                if (funct3 == 3'b000) op = op_addi;
                imm = {{20{fetch_inst[31]}}, fetch_inst[31:20]};
            end
            opc_op: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = op_add;
                    10'b0100000_000: op = op_sub;
                    10'b0000000_111: op = op_and;
                    10'b0000000_110: op = op_or;
                    10'b0000000_100: op = op_xor;
                    default:         op = op_nop;
                endcase
            end
            opc_load: begin
                if (funct3 == 3'b010) op = op_lw;
                imm = {{20{fetch_inst[31]}}, fetch_inst[31:20]};
            end
            opc_store: begin
                if (funct3 == 3'b010) op = op_sw;
                imm = {{20{fetch_inst[31]}}, fetch_inst[31:25], fetch_inst[11:7]};
            end
            opc_branch: begin
                if (funct3 == 3'b000) op = op_beq;
                if (funct3 == 3'b001) op = op_bne;
                imm = {{19{fetch_inst[31]}}, fetch_inst[31], fetch_inst[7],
                       fetch_inst[30:25], fetch_inst[11:8], 1'b0};
            end
            opc_jal: begin
                op  = op_jal;
                imm = {{11{fetch_inst[31]}}, fetch_inst[31], fetch_inst[19:12],
                       fetch_inst[20], fetch_inst[30:21], 1'b0};
            end
            default: op = op_nop;
        endcase
    end

    assign uses_rs1  = !(op inside {op_nop, op_lui, op_jal});
    assign uses_rs2  = op inside {op_add, op_sub, op_and, op_or, op_xor, op_sw, op_beq, op_bne};
    assign writes_rd = op inside {op_lui, op_addi, op_add, op_sub, op_and, op_or, op_xor,
                                  op_lw, op_jal};

    // unused fields read as x0 so they never stall
    assign rs1      = uses_rs1 ? fetch_inst[19:15] : '0;
    assign rs2      = uses_rs2 ? fetch_inst[24:20] : '0;
    assign issue_rd = writes_rd ? fetch_inst[11:7] : '0;

    assign stall    = fetch_valid && (rs1_pending || rs2_pending);
    assign advance  = !mem_wait && !busy;
    assign issue    = advance && !flush && fetch_valid && !stall;
    assign issue_en = issue && writes_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            d.valid <= 1'b0;
        end else if (advance) begin
            d.valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            d.pc       <= fetch_pc;
            d.op       <= op;
            d.rd       <= issue_rd;
            d.rs1_data <= rs1_data;
            d.rs2_data <= rs2_data;
            d.imm      <= imm;
        end
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output logic      rs1_pending,
    output word_t     rs2_data,
    output logic      rs2_pending,
    input  logic      issue_en,
    input  reg_addr_t issue_rd,
    input  logic      flush_rd_en,
    input  reg_addr_t flush_rd,
    input  logic      wb_en,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data
);

    word_t      regs [1:31];
    // up to three writes to one register can be in flight
    logic [1:0] pend [1:31];

    assign rs1_data    = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data    = (rs2 == '0) ? '0 : regs[rs2];
    assign rs1_pending = (rs1 != '0) && (pend[rs1] != '0);
    assign rs2_pending = (rs2 != '0) && (pend[rs2] != '0);

    always_ff @(posedge clk) begin
        if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    for (genvar i = 1; i < 32; i++) begin : g_pend
        logic inc;
        logic dec_wb;
        logic dec_fl;

        assign inc    = issue_en && (issue_rd == reg_addr_t'(i));
        assign dec_wb = wb_en && (wb_rd == reg_addr_t'(i));
        assign dec_fl = flush_rd_en && (flush_rd == reg_addr_t'(i));

        always_ff @(posedge clk) begin
            if (rst) begin
                pend[i] <= '0;
            end else begin
                pend[i] <= pend[i] + 2'(inc) - 2'(dec_wb) - 2'(dec_fl);
            end
        end
    end

endmodule

`default_nettype wire

// File: exec/exec.sv
`timescale 1ns/1ps
`default_nettype none

module exec import core_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  mem_wait,
    input  logic  busy,
    dec_if.dst    d,
    exe_if.src    e,
    output logic  flush,
    output word_t jmp_pc
);

    word_t result;
    word_t addr;
    word_t target;
    logic  taken;
    logic  advance;
    logic  go;

    always_comb begin
        case (d.op)
            op_lui:  result = d.imm;
            op_addi: result = d.rs1_data + d.imm;
            op_add:  result = d.rs1_data + d.rs2_data;
            op_sub:  result = d.rs1_data - d.rs2_data;
            op_and:  result = d.rs1_data & d.rs2_data;
            op_or:   result = d.rs1_data | d.rs2_data;
            op_xor:  result = d.rs1_data ^ d.rs2_data;
            // link address
            op_jal:  result = d.pc + 32'd4;
            default: result = '0;
        endcase
    end

    assign addr   = d.rs1_data + d.imm;
    assign target = d.pc + d.imm;

    assign taken = (d.op == op_jal)
                || (d.op == op_beq && d.rs1_data == d.rs2_data)
                || (d.op == op_bne && d.rs1_data != d.rs2_data);

    assign advance = !mem_wait && !busy;
    // the instruction behind a redirect is dropped
    assign go      = d.valid && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            e.valid <= 1'b0;
            flush   <= 1'b0;
        end else if (advance) begin
            e.valid <= go;
            flush   <= go && taken;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && go) begin
            e.op     <= d.op;
            e.rd     <= d.rd;
            e.result <= result;
            e.addr   <= addr;
            e.wdata  <= d.rs2_data;
            jmp_pc   <= target;
        end
    end

endmodule

`default_nettype wire

// File: mread/mread.sv
`timescale 1ns/1ps
`default_nettype none

module mread import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      mem_wait,
    exe_if.dst        e,
    output logic      busy,
    output logic      data_rden,
    output word_t     data_riaddr,
    input  logic      data_rvalid,
    input  word_t     data_roaddr,
    input  word_t     data_rdata,
    output logic      data_wren,
    output word_t     data_waddr,
    output word_t     data_wdata,
    output logic      wb_en,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    typedef enum logic [1:0] {st_idle, st_wait, st_done} mread_state_t;

    mread_state_t state;
    word_t        addr_q;
    logic         accept;
    logic         hit;
    logic         load_done;
    logic         is_load;
    logic         is_store;
    logic         writes_rd;

    assign is_load   = e.op == op_lw;
    assign is_store  = e.op == op_sw;
    assign writes_rd = e.op inside {op_lui, op_addi, op_add, op_sub, op_and, op_or, op_xor,
                                    op_jal};

    assign busy      = state == st_wait;
    assign accept    = !mem_wait && !busy && e.valid;
    assign hit       = data_rden && data_rvalid && (data_roaddr == addr_q);
    assign load_done = busy && !mem_wait && hit;

    assign data_riaddr = addr_q;
    assign data_waddr  = addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            data_rden <= 1'b0;
            data_wren <= 1'b0;
            wb_en     <= 1'b0;
        end else begin
            data_wren <= accept && is_store;
            case (state)
                st_wait: begin
                    wb_en <= load_done;
                    if (load_done) begin
                        state     <= st_done;
                        data_rden <= 1'b0;
                    end
                end
                // done is the load writeback cycle and accepts like idle
                default: begin
                    state     <= (accept && is_load) ? st_wait : st_idle;
                    data_rden <= accept && is_load;
                    wb_en     <= accept && writes_rd;
                end
            endcase
        end
    end

    // writeback source is either the result or the load data
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q     <= e.addr;
            data_wdata <= e.wdata;
            wb_rd      <= e.rd;
            wb_data    <= e.result;
        end else if (load_done) begin
            wb_data <= data_rdata;
        end
    end

endmodule

`default_nettype wire

// File: logic/core.sv
`timescale 1ns/1ps
`default_nettype none

module core import core_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    // instruction port
    output logic  inst_rden,
    output word_t inst_riaddr,
    input  word_t inst_roaddr,
    input  logic  inst_rvalid,
    input  inst_t inst_rdata,

    // data port
    output logic  data_rden,
    output word_t data_riaddr,
    input  word_t data_roaddr,
    input  logic  data_rvalid,
    input  word_t data_rdata,
    output logic  data_wren,
    output word_t data_waddr,
    output word_t data_wdata,

    input  logic  mem_wait
);

    dec_if dec_bus ();
    exe_if exe_bus ();

    logic      flush;
    logic      stall;
    logic      busy;
    word_t     jmp_pc;
    logic      fetch_valid;
    word_t     fetch_pc;
    inst_t     fetch_inst;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      rs1_pending;
    logic      rs2_pending;
    logic      issue_en;
    reg_addr_t issue_rd;
    logic      flush_rd_en;
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;

    // squashed instruction sitting in front of execute gives back its rd
    assign flush_rd_en = flush && dec_bus.valid && !mem_wait && !busy;

    fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .mem_wait    (mem_wait),
        .busy        (busy),
        .stall       (stall),
        .flush       (flush),
        .jmp_pc      (jmp_pc),
        .inst_rden   (inst_rden),
        .inst_riaddr (inst_riaddr),
        .inst_rvalid (inst_rvalid),
        .inst_roaddr (inst_roaddr),
        .inst_rdata  (inst_rdata),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst)
    );

    decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .mem_wait    (mem_wait),
        .busy        (busy),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst),
        .stall       (stall),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_pending (rs1_pending),
        .rs2_pending (rs2_pending),
        .issue_rd    (issue_rd),
        .issue_en    (issue_en),
        .d           (dec_bus.src)
    );

    reg_file u_reg_file (
        .clk         (clk),
        .rst         (rst),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_data    (rs1_data),
        .rs1_pending (rs1_pending),
        .rs2_data    (rs2_data),
        .rs2_pending (rs2_pending),
        .issue_en    (issue_en),
        .issue_rd    (issue_rd),
        .flush_rd_en (flush_rd_en),
        .flush_rd    (dec_bus.rd),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    exec u_exec (
        .clk      (clk),
        .rst      (rst),
        .mem_wait (mem_wait),
        .busy     (busy),
        .d        (dec_bus.dst),
        .e        (exe_bus.src),
        .flush    (flush),
        .jmp_pc   (jmp_pc)
    );

    mread u_mread (
        .clk         (clk),
        .rst         (rst),
        .mem_wait    (mem_wait),
        .e           (exe_bus.dst),
        .busy        (busy),
        .data_rden   (data_rden),
        .data_riaddr (data_riaddr),
        .data_rvalid (data_rvalid),
        .data_roaddr (data_roaddr),
        .data_rdata  (data_rdata),
        .data_wren   (data_wren),
        .data_waddr  (data_waddr),
        .data_wdata  (data_wdata),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

endmodule

`default_nettype wire

// File: verification/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb import core_pkg::*; ();

    logic      clk;
    logic      rst;
    logic      mem_wait;
    logic      inst_rden;
    word_t     inst_riaddr;
    word_t     inst_roaddr;
    logic      inst_rvalid;
    inst_t     inst_rdata;
    logic      data_rden;
    word_t     data_riaddr;
    word_t     data_roaddr;
    logic      data_rvalid;
    word_t     data_rdata;
    logic      data_wren;
    word_t     data_waddr;
    word_t     data_wdata;

    inst_t     imem [word_t];
    word_t     dmem [word_t];
    word_t     load_pc;
    word_t     lfsr;
    logic      stress;
    int        value_errors;
    int        other_errors;
    word_t     exp_addr [$];
    word_t     exp_data [$];
    word_t     got_addr [$];
    word_t     got_data [$];
    word_t     read_addr_q [$];
    reg_addr_t wb_rd_q [$];
    word_t     wb_data_q [$];

    // memory model state
    logic      imem_busy;
    int        imem_cnt;
    word_t     imem_addr;
    logic      dmem_busy;
    int        dmem_cnt;
    word_t     dmem_addr;

    core DUT (
        .clk         (clk),
        .rst         (rst),
        .inst_rden   (inst_rden),
        .inst_riaddr (inst_riaddr),
        .inst_roaddr (inst_roaddr),
        .inst_rvalid (inst_rvalid),
        .inst_rdata  (inst_rdata),
        .data_rden   (data_rden),
        .data_riaddr (data_riaddr),
        .data_roaddr (data_roaddr),
        .data_rvalid (data_rvalid),
        .data_rdata  (data_rdata),
        .data_wren   (data_wren),
        .data_waddr  (data_waddr),
        .data_wdata  (data_wdata),
        .mem_wait    (mem_wait)
    );

    always #5 clk = ~clk;

    function automatic word_t lfsr_next(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    function automatic int latency();
        if (stress) begin
            return 2 + int'(rand_bits(3));
        end
        return 1 + int'(rand_bits(2) % 3);
    endfunction

    function automatic inst_t lui(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, opc_lui};
    endfunction

    function automatic inst_t alu_imm(input reg_addr_t rd, input reg_addr_t rs1,
                                      input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, opc_opimm};
    endfunction

    function automatic inst_t alu_reg(input logic [6:0] f7, input logic [2:0] f3,
                                      input reg_addr_t rd, input reg_addr_t rs1,
                                      input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic inst_t load_word(input reg_addr_t rd, input reg_addr_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, opc_load};
    endfunction

    function automatic inst_t store_word(input reg_addr_t rs2, input reg_addr_t rs1,
                                         input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic inst_t branch(input logic [2:0] f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
    endfunction

    function automatic inst_t jump(input reg_addr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
    endfunction

    // unwritten code reads as addi x0 with a folded address
    function automatic inst_t imem_word(input word_t a);
        if (imem.exists(a)) begin
            return imem[a];
        end
        return alu_imm(0, 0, a[11:0] ^ a[23:12] ^ {a[31:24], 4'h0});
    endfunction

    function automatic word_t dmem_word(input word_t a);
        if (dmem.exists(a)) begin
            return dmem[a];
        end
        return a ^ 32'h9e37_79b9;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t got,
                                  input reg_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // instruction memory, one request at a time
    always @(negedge clk) begin
        if (rst) begin
            inst_rvalid <= 1'b0;
            imem_busy = 1'b0;
        end else begin
            inst_rvalid <= 1'b0;
            if (imem_busy) begin
                imem_cnt = imem_cnt - 1;
                if (imem_cnt == 0) begin
                    inst_rvalid <= 1'b1;
                    inst_roaddr <= imem_addr;
                    inst_rdata  <= imem_word(imem_addr);
                    imem_busy = 1'b0;
                end
            end else if (inst_rden) begin
                imem_addr = inst_riaddr;
                imem_cnt  = latency();
                imem_busy = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            data_rvalid <= 1'b0;
            dmem_busy = 1'b0;
        end else begin
            data_rvalid <= 1'b0;
            if (dmem_busy) begin
                dmem_cnt = dmem_cnt - 1;
                if (dmem_cnt == 0) begin
                    data_rvalid <= 1'b1;
                    data_roaddr <= dmem_addr;
                    data_rdata  <= dmem_word(dmem_addr);
                    dmem_busy = 1'b0;
                end
            end else if (data_rden) begin
                dmem_addr = data_riaddr;
                read_addr_q.push_back(data_riaddr);
                dmem_cnt  = latency();
                dmem_busy = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && data_wren) begin
            got_addr.push_back(data_waddr);
            got_data.push_back(data_wdata);
            dmem[data_waddr] = data_wdata;
        end
        // writebacks to x0 carry nothing
        if (!rst && DUT.wb_en && DUT.wb_rd != '0) begin
            wb_rd_q.push_back(DUT.wb_rd);
            wb_data_q.push_back(DUT.wb_data);
        end
    end

    always @(negedge clk) begin
        if (stress && !rst) begin
            mem_wait <= (rand_bits(2) == 2'b11);
        end else begin
            mem_wait <= 1'b0;
        end
    end

    task automatic check_idle_ports();
        check_flag("inst_rden", inst_rden, 1'b0);
        check_flag("data_rden", data_rden, 1'b0);
        check_flag("data_wren", data_wren, 1'b0);
    endtask

    task automatic enter_reset();
        @(negedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_idle_ports();
        imem.delete();
        dmem.delete();
        got_addr.delete();
        got_data.delete();
        exp_addr.delete();
        exp_data.delete();
        read_addr_q.delete();
        wb_rd_q.delete();
        wb_data_q.delete();
        load_pc = start_addr;
    endtask

    task automatic leave_reset();
        int waited;
        repeat (4) begin
            @(negedge clk);
            check_idle_ports();
        end
        rst <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            check_flag("data_rden", data_rden, 1'b0);
            check_flag("data_wren", data_wren, 1'b0);
        end while (!inst_rden && waited < 20);
        if (!inst_rden) begin
            other_errors++;
            $display("no instruction request within 20 cycles after reset");
        end else begin
            check_word("inst_riaddr", inst_riaddr, start_addr);
        end
    endtask

    task automatic emit(input inst_t inst);
        imem[load_pc] = inst;
        load_pc = load_pc + 32'd4;
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic compare_stores();
        int    waited;
        int    n;
        word_t addr;
        word_t data;
        n = exp_addr.size();
        for (int i = 0; i < n; i++) begin
            waited = 0;
            while (got_addr.size() == 0 && waited < 3000) begin
                @(posedge clk);
                waited++;
            end
            if (got_addr.size() == 0) begin
                other_errors++;
                $display("timed out waiting for store %0d of %0d", i + 1, n);
                return;
            end
            addr = got_addr.pop_front();
            data = got_data.pop_front();
            check_word("data_waddr", addr, exp_addr[i]);
            check_word("data_wdata", data, exp_data[i]);
        end
        // the program spins on its last jal, so nothing more may store
        repeat (40) @(posedge clk);
        if (got_addr.size() != 0) begin
            other_errors++;
            $display("%0d unexpected stores after the program ended", got_addr.size());
        end
    endtask

    task automatic alu_chain();
        word_t base;
        word_t a;
        word_t b;
        base = 32'h1000_0000;
        a    = 32'h1234_5678;
        b    = 32'hffff_ff00;
        enter_reset();
        emit(lui(1, base[31:12]));
        emit(lui(2, a[31:12]));
        emit(alu_imm(2, 2, a[11:0]));
        emit(alu_imm(3, 0, b[11:0]));
        emit(alu_reg(7'b0000000, 3'b000, 4, 2, 3));
        emit(alu_reg(7'b0100000, 3'b000, 5, 4, 2));
        emit(alu_reg(7'b0000000, 3'b111, 6, 2, 3));
        emit(alu_reg(7'b0000000, 3'b110, 7, 2, 3));
        emit(alu_reg(7'b0000000, 3'b100, 8, 7, 6));
        for (int r = 2; r <= 8; r++) begin
            emit(store_word(reg_addr_t'(r), 1, 12'(4 * (r - 2))));
        end
        emit(jump(0, '0));
        expect_store(base, a);
        expect_store(base + 4, b);
        expect_store(base + 8, a + b);
        expect_store(base + 12, (a + b) - a);
        expect_store(base + 16, a & b);
        expect_store(base + 20, a | b);
        expect_store(base + 24, (a | b) ^ (a & b));
        leave_reset();
        compare_stores();
    endtask

    task automatic load_use();
        word_t base;
        word_t w;
        base = 32'h1000_0000;
        w    = 32'hcafe_0123;
        enter_reset();
        dmem[base + 32'h40] = w;
        emit(lui(1, base[31:12]));
        emit(load_word(2, 1, 12'h040));
        emit(alu_imm(3, 2, 12'h055));
        emit(store_word(3, 1, 12'h080));
        emit(store_word(2, 1, 12'h084));
        emit(jump(0, '0));
        expect_store(base + 32'h80, w + 32'h55);
        expect_store(base + 32'h84, w);
        leave_reset();
        compare_stores();
        if (read_addr_q.size() == 0) begin
            other_errors++;
            $display("no data read request was seen for the load");
        end
        foreach (read_addr_q[i]) begin
            check_word("data_riaddr", read_addr_q[i], base + 32'h40);
        end
    endtask

    task automatic branch_paths();
        word_t base;
        base = 32'h1000_0000;
        enter_reset();
        emit(lui(1, base[31:12]));
        emit(alu_imm(2, 0, 12'd5));
        emit(alu_imm(3, 0, 12'd5));
        emit(alu_imm(4, 0, 12'd7));
        emit(alu_imm(9, 0, 12'd1));
        // beq taken over a store
        emit(branch(3'b000, 2, 3, 13'd8));
        emit(store_word(4, 1, 12'h100));
        emit(store_word(2, 1, 12'h104));
        emit(branch(3'b000, 2, 4, 13'd8));
        emit(store_word(3, 1, 12'h108));
        // bne taken over a store
        emit(branch(3'b001, 2, 4, 13'd8));
        emit(store_word(4, 1, 12'h10c));
        emit(store_word(4, 1, 12'h110));
        emit(branch(3'b001, 2, 3, 13'd8));
        emit(store_word(9, 1, 12'h114));
        emit(jump(0, '0));
        expect_store(base + 32'h104, 32'd5);
        expect_store(base + 32'h108, 32'd5);
        expect_store(base + 32'h110, 32'd7);
        expect_store(base + 32'h114, 32'd1);
        leave_reset();
        compare_stores();
    endtask

    task automatic jump_link();
        word_t base;
        base = 32'h1000_0000;
        enter_reset();
        emit(lui(1, base[31:12]));
        emit(jump(5, 21'd8));
        emit(store_word(1, 1, 12'h204));
        emit(store_word(5, 1, 12'h200));
        emit(jump(0, '0));
        expect_store(base + 32'h200, start_addr + 32'd8);
        leave_reset();
        compare_stores();
        if (wb_rd_q.size() != 2) begin
            other_errors++;
            $display("expected 2 register writebacks but saw %0d", wb_rd_q.size());
        end else begin
            check_reg_addr("wb_rd", wb_rd_q[0], 5'd1);
            check_word("wb_data", wb_data_q[0], base);
            check_reg_addr("wb_rd", wb_rd_q[1], 5'd5);
            check_word("wb_data", wb_data_q[1], start_addr + 32'd8);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        mem_wait     = 1'b0;
        inst_rvalid  = 1'b0;
        inst_roaddr  = '0;
        inst_rdata   = '0;
        data_rvalid  = 1'b0;
        data_roaddr  = '0;
        data_rdata   = '0;
        stress       = 1'b0;
        lfsr         = 32'h0175_8e9d;
        value_errors = 0;
        other_errors = 0;

        alu_chain();
        load_use();
        branch_paths();
        jump_link();

        // same programs with mem_wait pulses and slow memories
        stress = 1'b1;
        alu_chain();
        load_use();
        stress = 1'b0;

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
common/core_pkg.sv
common/stage_if.sv
fetch/fetch.sv
decode/decode.sv
logic/reg_file.sv
exec/exec.sv
mread/mread.sv
logic/core.sv
verification/core_tb.sv

// File: Bender.yml
package:
  name: core

sources:
  - common/core_pkg.sv
  - common/stage_if.sv
  - fetch/fetch.sv
  - decode/decode.sv
  - logic/reg_file.sv
  - exec/exec.sv
  - mread/mread.sv
  - logic/core.sv
  - target: test
    files:
      - verification/core_tb.sv
